// File: include/memDefs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

`define RST 1'b1

`endif

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tbMemSys
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/VtbMemSys)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

// File: src.f
+incdir+include
verilog/axiPkg.sv
verilog/AxiIO.sv
verilog/RAMHelper.sv
verilog/SimRam.sv
verilog/AxiMaster.sv
verilog/MemSysTop.sv
verif/tbMemSys.sv

// File: verif/tbMemSys.sv
`timescale 1ns/1ns

module tbMemSys;
    import axiPkg::*;

    localparam int NUM_TXN = 200;
    localparam int MEM_BYTES = 2048;
    localparam int CYCLE_LIMIT = NUM_TXN * 40;

    logic clk;
    logic rst;
    logic cmdValid;
    logic cmdWrite;
    logic [ADDR_W-1:0] cmdAddr;
    logic [3:0] cmdLen;
    logic [1:0] cmdSize;
    logic [1:0] cmdBurst;
    logic wrValid;
    logic [DATA_W-1:0] wrData;
    logic [STRB_W-1:0] wrStrb;
    logic rdValid;
    logic [DATA_W-1:0] rdData;
    logic rdLast;
    logic wrDone;
    logic busy;

    // byte-wide reference copy of the whole memory.
    logic [7:0] model [MEM_BYTES];
    int seed;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int beatsSeen;
    int donesSeen;

    MemSysTop #(
        .DEPTH(MEM_BYTES / 8)
    ) dut (
        .clk(clk),
        .rst(rst),
        .cmdValid(cmdValid),
        .cmdWrite(cmdWrite),
        .cmdAddr(cmdAddr),
        .cmdLen(cmdLen),
        .cmdSize(cmdSize),
        .cmdBurst(cmdBurst),
        .wrValid(wrValid),
        .wrData(wrData),
        .wrStrb(wrStrb),
        .rdValid(rdValid),
        .rdData(rdData),
        .rdLast(rdLast),
        .wrDone(wrDone),
        .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles.", cycles);
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    // outputs are sampled and inputs driven 2 ns after each rising edge.
    task automatic nextCycle();
        @(posedge clk);
        #2;
        if (rdValid) beatsSeen++;
        if (wrDone) donesSeen++;
    endtask

    task automatic checkValue(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [DATA_W-1:0] laneMask(input int nBytes);
        return (nBytes == 8) ? '1 : (64'd1 << (8 * nBytes)) - 64'd1;
    endfunction

    // model bytes starting at base, packed into the low lanes.
    function automatic logic [DATA_W-1:0] modelBeat(input int base, input int nBytes);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int j = 0; j < nBytes; j++) begin
            v[8*j +: 8] = model[(base + j) % MEM_BYTES];
        end
        return v;
    endfunction

    task automatic issueCommand(input logic write, input int addr, input int len,
                                input int size, input int burst);
        cmdValid = 1'b1;
        cmdWrite = write;
        cmdAddr = ADDR_W'(addr);
        cmdLen = 4'(len);
        cmdSize = 2'(size);
        cmdBurst = 2'(burst);
        beatsSeen = 0;
        donesSeen = 0;
        nextCycle();
        cmdValid = 1'b0;
    endtask

    task automatic runRead(input int addr, input int len, input int size, input int burst);
        int nBytes;
        int nBeats;
        logic [DATA_W-1:0] mask;
        nBytes = 1 << size;
        nBeats = (burst == BURST_FIXED) ? 1 : len + 1;
        mask = laneMask(nBytes);
        issueCommand(1'b0, addr, len, size, burst);
        while (busy) begin
            nextCycle();
            if (rdValid) begin
                checkValue(rdData & mask, modelBeat(addr + (beatsSeen - 1) * nBytes, nBytes),
                           "read beat");
                checkValue(rdLast, beatsSeen == nBeats, "rdLast");
            end
        end
        checkValue(beatsSeen, nBeats, "read beat count");
        checkValue(donesSeen, 0, "write completions during read");
    endtask

    task automatic runWrite(input int addr, input int len, input int size, input int burst);
        int nBytes;
        int base;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        nBytes = 1 << size;
        issueCommand(1'b1, addr, len, size, burst);
        for (int k = 0; k <= len; k++) begin
            data = {$random(seed), $random(seed)};
            strb = STRB_W'($random(seed));
            wrValid = 1'b1;
            wrData = data;
            wrStrb = strb;
            // a FIXED burst keeps only its first beat.
            if (burst == BURST_INCR || k == 0) begin
                base = addr + k * nBytes;
                for (int j = 0; j < nBytes; j++) begin
                    if (strb[j]) model[(base + j) % MEM_BYTES] = data[8*j +: 8];
                end
            end
            nextCycle();
        end
        wrValid = 1'b0;
        while (busy) nextCycle();
        checkValue(donesSeen, 1, "write completion count");
        checkValue(beatsSeen, 0, "read beats during write");
    endtask

    initial begin
        int addr;
        int len;
        int size;
        int burst;
        logic write;
        seed = 32'h3d2e;
        for (int i = 0; i < MEM_BYTES; i++) model[i] = 8'h00;
        rst = 1'b1;
        cmdValid = 1'b0;
        cmdWrite = 1'b0;
        cmdAddr = '0;
        cmdLen = '0;
        cmdSize = '0;
        cmdBurst = '0;
        wrValid = 1'b0;
        wrData = '0;
        wrStrb = '0;
        beatsSeen = 0;
        donesSeen = 0;
        repeat (4) nextCycle();
        rst = 1'b0;

        checkValue(busy, 1'b0, "busy after reset");
        checkValue(rdValid, 1'b0, "rdValid after reset");
        checkValue(rdLast, 1'b0, "rdLast after reset");
        checkValue(wrDone, 1'b0, "wrDone after reset");
        // nothing written yet, so this full-word read must return zeros.
        runRead((($random(seed) & 255) * 8), 15, 3, BURST_INCR);

        for (int t = 0; t < NUM_TXN; t++) begin
            while (busy) nextCycle();
            write = 1'($random(seed) & 1);
            addr = ($random(seed) & 31) * 8;
            size = $random(seed) & 3;
            len = $random(seed) & 15;
            burst = (($random(seed) & 3) == 0) ? BURST_FIXED : BURST_INCR;
            if (write) begin
                runWrite(addr, len, size, burst);
            end else begin
                runRead(addr, len, size, burst);
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/AxiIO.sv
`timescale 1ns/1ns

interface AxiIO;
    import axiPkg::*;

    // read address channel.
    logic marValid;
    logic [ADDR_W-1:0] marAddr;
    logic [7:0] marLen;
    logic [2:0] marSize;
    logic [1:0] marBurst;
    logic [ID_W-1:0] marId;
    logic sarReady;

    // write address channel.
    logic mawValid;
    logic [ADDR_W-1:0] mawAddr;
    logic [7:0] mawLen;
    logic [2:0] mawSize;
    logic [1:0] mawBurst;
    logic [ID_W-1:0] mawId;
    logic sawReady;

    // write data channel.
    logic mwValid;
    logic [DATA_W-1:0] mwData;
    logic [STRB_W-1:0] mwStrb;
    logic mwLast;
    logic swReady;

    // read data and write response carry no ready from the master.
    logic srValid;
    logic [DATA_W-1:0] srData;
    logic [ID_W-1:0] srId;
    logic [1:0] srResp;
    logic srLast;
    logic sbValid;
    logic [ID_W-1:0] sbId;
    logic [1:0] sbResp;

    modport master (
        output marValid, marAddr, marLen, marSize, marBurst, marId,
        output mawValid, mawAddr, mawLen, mawSize, mawBurst, mawId,
        output mwValid, mwData, mwStrb, mwLast,
        input sarReady, sawReady, swReady,
        input srValid, srData, srId, srResp, srLast,
        input sbValid, sbId, sbResp
    );

    modport slave (
        input marValid, marAddr, marLen, marSize, marBurst, marId,
        input mawValid, mawAddr, mawLen, mawSize, mawBurst, mawId,
        input mwValid, mwData, mwStrb, mwLast,
        output sarReady, sawReady, swReady,
        output srValid, srData, srId, srResp, srLast,
        output sbValid, sbId, sbResp
    );

endinterface

// File: verilog/AxiMaster.sv
`timescale 1ns/1ns
`include "memDefs.svh"

module AxiMaster (
    input logic clk,
    input logic rst,
    input logic cmdValid,
    input logic cmdWrite,
    input logic [axiPkg::ADDR_W-1:0] cmdAddr,
    input logic [3:0] cmdLen,
    input logic [1:0] cmdSize,
    input logic [1:0] cmdBurst,
    input logic wrValid,
    input logic [axiPkg::DATA_W-1:0] wrData,
    input logic [axiPkg::STRB_W-1:0] wrStrb,
    output logic rdValid,
    output logic [axiPkg::DATA_W-1:0] rdData,
    output logic rdLast,
    output logic wrDone,
    output logic busy,
    AxiIO.master axi
);
    import axiPkg::*;

    logic isWrite;
    logic addrValid;
    logic addrFire;
    logic dataPhase;
    logic [ADDR_W-1:0] curAddr;
    logic [3:0] curLen;
    logic [1:0] curSize;
    logic [1:0] curBurst;
    logic [ID_W-1:0] curId;
    logic [DATA_W-1:0] wrBuf [16];
    logic [STRB_W-1:0] strbBuf [16];
    logic [4:0] rcvCnt;
    logic [4:0] sendIdx;
    logic [3:0] lastIdx;
    logic capture;

    assign addrFire = addrValid && (isWrite ? axi.sawReady : axi.sarReady);
    assign capture = busy && isWrite && wrValid && !rcvCnt[4];
    // a FIXED burst carries a single beat.
    assign lastIdx = (curBurst == BURST_FIXED) ? 4'd0 : curLen;

    always_ff @(posedge clk) begin
        if (capture) begin
            wrBuf[rcvCnt[3:0]] <= wrData;
            strbBuf[rcvCnt[3:0]] <= wrStrb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst == `RST) begin
            busy <= 1'b0;
            isWrite <= 1'b0;
            addrValid <= 1'b0;
            dataPhase <= 1'b0;
            rcvCnt <= '0;
            sendIdx <= '0;
            curId <= '0;
        end else begin
            if (cmdValid && !busy) begin
                busy <= 1'b1;
                isWrite <= cmdWrite;
                addrValid <= 1'b1;
                curAddr <= cmdAddr;
                curLen <= cmdLen;
                curSize <= cmdSize;
                curBurst <= (cmdBurst == BURST_INCR) ? BURST_INCR : BURST_FIXED;
                curId <= curId + 1'b1;
                rcvCnt <= '0;
                sendIdx <= '0;
            end
            if (addrFire) begin
                addrValid <= 1'b0;
                dataPhase <= isWrite;
            end
            if (capture) begin
                rcvCnt <= rcvCnt + 1'b1;
            end
            if (axi.mwValid && axi.swReady) begin
                sendIdx <= sendIdx + 1'b1;
                if (axi.mwLast) begin
                    dataPhase <= 1'b0;
                end
            end
            if (rdLast || wrDone) begin
                busy <= 1'b0;
            end
        end
    end

    assign axi.marValid = addrValid && !isWrite;
    assign axi.marAddr = curAddr;
    assign axi.marLen = {4'd0, curLen};
    assign axi.marSize = {1'b0, curSize};
    assign axi.marBurst = curBurst;
    assign axi.marId = curId;

    assign axi.mawValid = addrValid && isWrite;
    assign axi.mawAddr = curAddr;
    assign axi.mawLen = {4'd0, curLen};
    assign axi.mawSize = {1'b0, curSize};
    assign axi.mawBurst = curBurst;
    assign axi.mawId = curId;

    // a beat is offered only once the testbench has delivered it.
    assign axi.mwValid = dataPhase && (sendIdx < rcvCnt);
    assign axi.mwData = wrBuf[sendIdx[3:0]];
    assign axi.mwStrb = strbBuf[sendIdx[3:0]];
    assign axi.mwLast = (sendIdx[3:0] == lastIdx);

    assign rdValid = busy && !isWrite && axi.srValid && (axi.srId == curId);
    assign rdData = axi.srData;
    assign rdLast = rdValid && axi.srLast;
    assign wrDone = busy && isWrite && axi.sbValid && (axi.sbId == curId);

endmodule

// File: verilog/MemSysTop.sv
`timescale 1ns/1ns

module MemSysTop #(
    parameter int DEPTH = 256
) (
    input logic clk,
    input logic rst,
    input logic cmdValid,
    input logic cmdWrite,
    input logic [axiPkg::ADDR_W-1:0] cmdAddr,
    input logic [3:0] cmdLen,
    input logic [1:0] cmdSize,
    input logic [1:0] cmdBurst,
    input logic wrValid,
    input logic [axiPkg::DATA_W-1:0] wrData,
    input logic [axiPkg::STRB_W-1:0] wrStrb,
    output logic rdValid,
    output logic [axiPkg::DATA_W-1:0] rdData,
    output logic rdLast,
    output logic wrDone,
    output logic busy
);

    AxiIO axi ();

    AxiMaster bridge (
        .clk(clk),
        .rst(rst),
        .cmdValid(cmdValid),
        .cmdWrite(cmdWrite),
        .cmdAddr(cmdAddr),
        .cmdLen(cmdLen),
        .cmdSize(cmdSize),
        .cmdBurst(cmdBurst),
        .wrValid(wrValid),
        .wrData(wrData),
        .wrStrb(wrStrb),
        .rdValid(rdValid),
        .rdData(rdData),
        .rdLast(rdLast),
        .wrDone(wrDone),
        .busy(busy),
        .axi(axi.master)
    );

    SimRam #(
        .DEPTH(DEPTH)
    ) mem (
        .clk(clk),
        .rst(rst),
        .axi(axi.slave)
    );

endmodule

// File: verilog/RAMHelper.sv
`timescale 1ns/1ns

module RAMHelper #(
    parameter int DEPTH = 256,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input logic clk,
    input logic [IDX_W-1:0] rIdx,
    input logic [IDX_W-1:0] wIdx,
    input axiPkg::beatWord_t wdata,
    input axiPkg::beatWord_t wmask,
    input logic wen,
    output axiPkg::beatWord_t rdata
);
    import axiPkg::*;

    beatWord_t mem [DEPTH] = '{default: '0};

    // a lane is written when any bit of its mask byte is set.
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (|wmask.bytes[b]) begin
                    mem[wIdx].bytes[b] <= wdata.bytes[b];
                end
            end
        end
    end

    assign rdata = mem[rIdx];

endmodule

// File: verilog/SimRam.sv
`timescale 1ns/1ns
`include "memDefs.svh"

module SimRam #(
    parameter int DEPTH = 256
) (
    input logic clk,
    input logic rst,
    AxiIO.slave axi
);
    import axiPkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic [IDX_W-1:0] rIdx;
    logic [IDX_W-1:0] wIdx;
    beatWord_t rdata;
    beatWord_t wdataSh;
    beatWord_t wmaskLane;
    beatWord_t wmaskSh;
    logic [STRB_W-1:0] beatStrb;
    logic [STRB_W-1:0] wLaneMask;
    logic wen;

    // beats left in the burst, and byte counts of beat and word remainder.
    logic [8:0] arlen;
    logic [3:0] arsize;
    logic [3:0] rsize;
    logic [5:0] rshift;
    logic [8:0] wlen;
    logic [3:0] awsize;
    logic [3:0] wsize;
    logic [5:0] wshift;

    function automatic logic [3:0] sizeBytes(input logic [2:0] size);
        case (size)
            SIZE_1B: return 4'd1;
            SIZE_2B: return 4'd2;
            SIZE_4B: return 4'd4;
            SIZE_8B: return 4'd8;
            // wider beats do not fit the bus and clamp to a full word.
            default: return 4'd8;
        endcase
    endfunction

    // strobes above the beat size are dropped before the mask moves to its lane.
    assign beatStrb = axi.mwStrb & wLaneMask;

    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            wmaskLane.bytes[b] = {8{beatStrb[b]}};
        end
    end

    assign wdataSh.word = axi.mwData << wshift;
    assign wmaskSh.word = wmaskLane.word << wshift;
    assign wen = axi.swReady && axi.mwValid;

    assign axi.srResp = RESP_OKAY;
    assign axi.sbResp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst == `RST) begin
            axi.sarReady <= 1'b1;
            axi.srValid <= 1'b0;
            axi.srLast <= 1'b0;
            axi.sawReady <= 1'b1;
            axi.swReady <= 1'b0;
            axi.sbValid <= 1'b0;
        end else begin
            if (axi.marValid && axi.sarReady) begin
                axi.sarReady <= 1'b0;
                rIdx <= axi.marAddr[3 +: IDX_W];
                arlen <= (axi.marBurst == BURST_FIXED) ? 9'd1 : {1'b0, axi.marLen} + 9'd1;
                arsize <= sizeBytes(axi.marSize);
                axi.srId <= axi.marId;
                rsize <= 4'd8;
                rshift <= '0;
            end

            // sarReady stays low for as long as a read burst runs.
            if (!axi.sarReady) begin
                if (arlen == 9'd1) begin
                    axi.sarReady <= 1'b1;
                    axi.srLast <= 1'b1;
                end
                if (rsize <= arsize) begin
                    rIdx <= rIdx + 1'b1;
                    rsize <= 4'd8;
                    rshift <= '0;
                end else begin
                    rsize <= rsize - arsize;
                    rshift <= rshift + {arsize[2:0], 3'b000};
                end
                arlen <= arlen - 9'd1;
                axi.srData <= rdata.word >> rshift;
                axi.srValid <= 1'b1;
            end

            if (axi.srValid && axi.srLast) begin
                axi.srValid <= 1'b0;
                axi.srLast <= 1'b0;
            end

            if (axi.mawValid && axi.sawReady) begin
                axi.sawReady <= 1'b0;
                axi.swReady <= 1'b1;
                axi.sbId <= axi.mawId;
                wIdx <= axi.mawAddr[3 +: IDX_W];
                wlen <= (axi.mawBurst == BURST_FIXED) ? 9'd1 : {1'b0, axi.mawLen} + 9'd1;
                awsize <= sizeBytes(axi.mawSize);
                wLaneMask <= 8'hff >> (4'd8 - sizeBytes(axi.mawSize));
                wsize <= 4'd8;
                wshift <= '0;
            end

            if (wen) begin
                if (wsize <= awsize) begin
                    wIdx <= wIdx + 1'b1;
                    wsize <= 4'd8;
                    wshift <= '0;
                end else begin
                    wsize <= wsize - awsize;
                    wshift <= wshift + {awsize[2:0], 3'b000};
                end
                wlen <= wlen - 9'd1;
                if (axi.mwLast || wlen == 9'd1) begin
                    axi.swReady <= 1'b0;
                    axi.sbValid <= 1'b1;
                end
            end

            // the write address channel reopens once the response has gone out.
            if (axi.sbValid) begin
                axi.sbValid <= 1'b0;
                axi.sawReady <= 1'b1;
            end
        end
    end

    RAMHelper #(
        .DEPTH(DEPTH)
    ) ram (
        .clk(clk),
        .rIdx(rIdx),
        .wIdx(wIdx),
        .wdata(wdataSh),
        .wmask(wmaskSh),
        .wen(wen),
        .rdata(rdata)
    );

endmodule

// File: verilog/axiPkg.sv
package axiPkg;

    localparam int DATA_W = 64;
    localparam int ADDR_W = 32;
    localparam int ID_W = 4;
    localparam int STRB_W = DATA_W / 8;

    localparam logic [1:0] BURST_FIXED = 2'd0;
    localparam logic [1:0] BURST_INCR = 2'd1;

    // beat size codes as carried on the address channels.
    localparam logic [2:0] SIZE_1B = 3'd0;
    localparam logic [2:0] SIZE_2B = 3'd1;
    localparam logic [2:0] SIZE_4B = 3'd2;
    localparam logic [2:0] SIZE_8B = 3'd3;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // one memory word, seen either whole or as eight byte lanes.
    typedef union packed {
        logic [DATA_W-1:0] word;
        logic [STRB_W-1:0][7:0] bytes;
    } beatWord_t;

endpackage
